//--- hw/fmul_fmt_pkg.sv
// ################################################
// binary32 format
// field widths and typedefs of the operand fields
// ################################################

package fmul_fmt_pkg;

  localparam int exp_width  = 8;
  localparam int man_width  = 23;
  localparam int word_width = 32;

  typedef logic [word_width-1:0] fp_word_t;   // full operand or result
  typedef logic [exp_width-1:0] exp_t;        // biased exponent
  typedef logic [exp_width:0] exp_ext_t;      // exponent plus carry bit
  typedef logic [man_width:0] sig_t;          // significand with hidden one
  typedef logic [2*man_width+1:0] prod_t;     // full significand product
  typedef logic [man_width-1:0] man_t;        // stored mantissa
  typedef logic [exp_width+man_width-1:0] body_t;  // everything but the sign

endpackage

//--- hw/fmul_special_pkg.sv
// ################################################
// special encodings of binary32
// nan words, infinity, exponent bias
// ################################################

package fmul_special_pkg;

  localparam int exp_bias = 127;

  localparam fmul_fmt_pkg::exp_t exp_all_ones = 8'hFF;

  localparam fmul_fmt_pkg::fp_word_t quiet_nan_word = 32'h7FC00000;
  localparam fmul_fmt_pkg::fp_word_t sig_nan_word   = 32'h7FA00000;

  // sign is prepended by the user
  localparam fmul_fmt_pkg::body_t infinity_body =
    {exp_all_ones, fmul_fmt_pkg::man_t'(0)};

endpackage

//--- hw/fmul_operand_classify.sv
// ################################################
// operand classifier
// field split and zero / nan / infinity / denormal flags
// ################################################

`timescale 1ns/1ps

module fmul_operand_classify (
  input  fmul_fmt_pkg::fp_word_t op_i
  , output logic                 sign_o
  , output logic                 zero_o
  , output logic                 nan_o
  , output logic                 sig_nan_o
  , output logic                 infty_o
  , output logic                 denormal_o
  , output fmul_fmt_pkg::exp_t   exp_o
  , output fmul_fmt_pkg::man_t   man_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  assign sign_o = op_i[fmul_fmt_pkg::word_width-1];
  assign exp_o  = op_i[fmul_fmt_pkg::man_width +: fmul_fmt_pkg::exp_width];
  assign man_o  = op_i[fmul_fmt_pkg::man_width-1:0];

  assign exp_zero = (exp_o == '0);
  assign exp_ones = (exp_o == fmul_special_pkg::exp_all_ones);
  assign man_zero = (man_o == '0);

  assign zero_o     = exp_zero & man_zero;
  assign denormal_o = exp_zero & ~man_zero;
  assign infty_o    = exp_ones & man_zero;
  assign nan_o      = exp_ones & ~man_zero;
  assign sig_nan_o  = nan_o & ~man_o[fmul_fmt_pkg::man_width-1];  // quiet bit clear

endmodule

//--- hw/fmul_pipe_ctrl.sv
// ################################################
// pipeline control
// stage valid bits, stall and load enables
// ################################################

`timescale 1ns/1ps

module fmul_pipe_ctrl (
  input  logic clk_i
  , input  logic reset_i
  , input  logic en_i
  , input  logic v_i
  , input  logic yumi_i
  , output logic ready_o
  , output logic v_o
  , output logic load_1_o
  , output logic load_2_o
  , output logic load_3_o
);

  logic v_1_r, v_2_r, v_3_r;
  logic stall;
  logic advance;

  assign stall   = v_3_r & ~yumi_i;   // result waiting for consumer
  assign advance = en_i & ~stall;

  assign ready_o  = advance;
  assign v_o      = v_3_r;
  assign load_1_o = advance & v_i;
  assign load_2_o = advance & v_1_r;
  assign load_3_o = advance & v_2_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
      v_2_r <= 1'b0;
      v_3_r <= 1'b0;
    end else if (advance) begin
      v_1_r <= v_i;   // bubble when nothing offered
      v_2_r <= v_1_r;
      v_3_r <= v_2_r;
    end
  end

endmodule

//--- hw/fmul_operand_stage.sv
// ################################################
// stage 1
// operand classification, sign, exponent sum,
// significands with hidden one
// ################################################

`timescale 1ns/1ps

module fmul_operand_stage (
  input  logic                     clk_i
  , input  logic                   load_i
  , input  fmul_fmt_pkg::fp_word_t a_i
  , input  fmul_fmt_pkg::fp_word_t b_i
  , output logic                   sign_o
  , output fmul_fmt_pkg::exp_ext_t exp_sum_o
  , output fmul_fmt_pkg::exp_t     exp_unbiased_o
  , output fmul_fmt_pkg::sig_t     sig_a_o
  , output fmul_fmt_pkg::sig_t     sig_b_o
  , output logic a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o
  , output logic a_zero_o, b_zero_o, a_denormal_o, b_denormal_o
);

  logic sign_a, a_zero, a_nan, a_sig_nan, a_infty, a_denormal;
  logic sign_b, b_zero, b_nan, b_sig_nan, b_infty, b_denormal;
  fmul_fmt_pkg::exp_t exp_a, exp_b;
  fmul_fmt_pkg::man_t man_a, man_b;
  fmul_fmt_pkg::exp_ext_t exp_sum;
  fmul_fmt_pkg::exp_ext_t exp_diff;

  fmul_operand_classify i_classify_a (
    .op_i(a_i), .sign_o(sign_a), .zero_o(a_zero), .nan_o(a_nan)
    , .sig_nan_o(a_sig_nan), .infty_o(a_infty), .denormal_o(a_denormal)
    , .exp_o(exp_a), .man_o(man_a)
  );

  fmul_operand_classify i_classify_b (
    .op_i(b_i), .sign_o(sign_b), .zero_o(b_zero), .nan_o(b_nan)
    , .sig_nan_o(b_sig_nan), .infty_o(b_infty), .denormal_o(b_denormal)
    , .exp_o(exp_b), .man_o(man_b)
  );

  assign exp_sum  = {1'b0, exp_a} + {1'b0, exp_b};  // still carries two biases
  assign exp_diff = exp_sum - fmul_fmt_pkg::exp_ext_t'(fmul_special_pkg::exp_bias);

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      sign_o         <= sign_a ^ sign_b;
      exp_sum_o      <= exp_sum;
      exp_unbiased_o <= exp_diff[fmul_fmt_pkg::exp_width-1:0];  // wraps out of range
      sig_a_o        <= {1'b1, man_a};
      sig_b_o        <= {1'b1, man_b};
      {a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o}
        <= {a_sig_nan, b_sig_nan, a_nan, b_nan, a_infty, b_infty};
      {a_zero_o, b_zero_o, a_denormal_o, b_denormal_o}
        <= {a_zero, b_zero, a_denormal, b_denormal};
    end
  end

endmodule

//--- hw/fmul_product_stage.sv
// ################################################
// stage 2
// 24x24 significand multiply, side data carried along
// ################################################

`timescale 1ns/1ps

module fmul_product_stage (
  input  logic                     clk_i
  , input  logic                   load_i
  , input  fmul_fmt_pkg::sig_t     sig_a_i
  , input  fmul_fmt_pkg::sig_t     sig_b_i
  , input  logic                   sign_i
  , input  fmul_fmt_pkg::exp_ext_t exp_sum_i
  , input  fmul_fmt_pkg::exp_t     exp_unbiased_i
  , input  logic a_sig_nan_i, b_sig_nan_i, a_nan_i, b_nan_i, a_infty_i, b_infty_i
  , input  logic a_zero_i, b_zero_i, a_denormal_i, b_denormal_i
  , output fmul_fmt_pkg::prod_t    prod_o
  , output logic                   sign_o
  , output fmul_fmt_pkg::exp_ext_t exp_sum_o
  , output fmul_fmt_pkg::exp_t     exp_unbiased_o
  , output logic a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o
  , output logic a_zero_o, b_zero_o, a_denormal_o, b_denormal_o
);

  fmul_fmt_pkg::prod_t product;

  assign product = sig_a_i * sig_b_i;   // 48 bit context, no truncation

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      prod_o         <= product;
      sign_o         <= sign_i;
      exp_sum_o      <= exp_sum_i;
      exp_unbiased_o <= exp_unbiased_i;
      {a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o}
        <= {a_sig_nan_i, b_sig_nan_i, a_nan_i, b_nan_i, a_infty_i, b_infty_i};
      {a_zero_o, b_zero_o, a_denormal_o, b_denormal_o}
        <= {a_zero_i, b_zero_i, a_denormal_i, b_denormal_i};
    end
  end

endmodule

//--- hw/fmul_round_stage.sv
// ################################################
// stage 3
// one bit normalize, guard/round/sticky,
// round to nearest even decision
// ################################################

`timescale 1ns/1ps

module fmul_round_stage (
  input  logic                     clk_i
  , input  logic                   load_i
  , input  fmul_fmt_pkg::prod_t    prod_i
  , input  fmul_fmt_pkg::exp_t     exp_unbiased_i
  , input  logic                   sign_i
  , input  fmul_fmt_pkg::exp_ext_t exp_sum_i
  , input  logic a_sig_nan_i, b_sig_nan_i, a_nan_i, b_nan_i, a_infty_i, b_infty_i
  , input  logic a_zero_i, b_zero_i, a_denormal_i, b_denormal_i
  , output fmul_fmt_pkg::body_t    pre_round_o
  , output logic                   round_up_o
  , output logic                   exp_carry_o
  , output logic                   sign_o
  , output fmul_fmt_pkg::exp_ext_t exp_sum_o
  , output logic a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o
  , output logic a_zero_o, b_zero_o, a_denormal_o, b_denormal_o
);

  localparam int mw = fmul_fmt_pkg::man_width;

  logic top;
  fmul_fmt_pkg::prod_t aligned;
  fmul_fmt_pkg::exp_ext_t exp_norm;
  logic lsb, guard, round_bit, sticky;

  // product in [2,4) moves the binary point one place left
  assign top      = prod_i[2*mw+1];
  assign aligned  = top ? prod_i : (prod_i << 1);
  assign exp_norm = {1'b0, exp_unbiased_i} + fmul_fmt_pkg::exp_ext_t'(top);

  assign lsb       = aligned[mw+1];
  assign guard     = aligned[mw];
  assign round_bit = aligned[mw-1];
  assign sticky    = |aligned[mw-2:0];

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      pre_round_o <= {exp_norm[fmul_fmt_pkg::exp_width-1:0], aligned[mw+1 +: mw]};
      round_up_o  <= guard & (round_bit | sticky | lsb);  // ties go to even
      exp_carry_o <= exp_norm[fmul_fmt_pkg::exp_width];
      sign_o      <= sign_i;
      exp_sum_o   <= exp_sum_i;
      {a_sig_nan_o, b_sig_nan_o, a_nan_o, b_nan_o, a_infty_o, b_infty_o}
        <= {a_sig_nan_i, b_sig_nan_i, a_nan_i, b_nan_i, a_infty_i, b_infty_i};
      {a_zero_o, b_zero_o, a_denormal_o, b_denormal_o}
        <= {a_zero_i, b_zero_i, a_denormal_i, b_denormal_i};
    end
  end

endmodule

//--- hw/fmul_result_select.sv
// ################################################
// result selection
// final increment, exception priority, status flags
// ################################################

`timescale 1ns/1ps

module fmul_result_select (
  input  logic                     sign_i
  , input  fmul_fmt_pkg::body_t    pre_round_i
  , input  logic                   round_up_i
  , input  logic                   exp_carry_i
  , input  fmul_fmt_pkg::exp_ext_t exp_sum_i
  , input  logic a_sig_nan_i, b_sig_nan_i, a_nan_i, b_nan_i, a_infty_i, b_infty_i
  , input  logic a_zero_i, b_zero_i, a_denormal_i, b_denormal_i
  , output fmul_fmt_pkg::fp_word_t z_o
  , output logic                   invalid_o
  , output logic                   overflow_o
  , output logic                   underflow_o
  , output logic                   unimplemented_o
);

  fmul_fmt_pkg::body_t rounded;
  logic round_carry;
  fmul_fmt_pkg::exp_t rounded_exp;
  logic sum_low, sum_high;
  fmul_fmt_pkg::fp_word_t zero_word, infty_word;

  assign {round_carry, rounded} = pre_round_i + round_up_i;
  assign rounded_exp = rounded[fmul_fmt_pkg::man_width +: fmul_fmt_pkg::exp_width];

  // range of the biased sum is bias .. bias+255 for a usable exponent
  assign sum_low  = exp_sum_i < fmul_fmt_pkg::exp_ext_t'(fmul_special_pkg::exp_bias);
  assign sum_high = exp_sum_i > (fmul_fmt_pkg::exp_ext_t'(fmul_special_pkg::exp_bias)
                    + fmul_fmt_pkg::exp_ext_t'(fmul_special_pkg::exp_all_ones));

  assign zero_word  = {sign_i, fmul_fmt_pkg::body_t'(0)};
  assign infty_word = {sign_i, fmul_special_pkg::infinity_body};

  always_comb begin
    z_o             = {sign_i, rounded};
    invalid_o       = 1'b0;
    overflow_o      = 1'b0;
    underflow_o     = 1'b0;
    unimplemented_o = 1'b0;
    if (a_sig_nan_i | b_sig_nan_i) begin
      z_o       = fmul_special_pkg::sig_nan_word;
      invalid_o = 1'b1;
    end else if (a_nan_i | b_nan_i) begin
      z_o = fmul_special_pkg::quiet_nan_word;
    end else if ((a_infty_i & b_zero_i) | (b_infty_i & a_zero_i)) begin
      z_o       = fmul_special_pkg::quiet_nan_word;
      invalid_o = 1'b1;
    end else if (a_infty_i | b_infty_i) begin
      z_o = infty_word;
    end else if (a_zero_i | b_zero_i) begin
      z_o = zero_word;
    end else if (a_denormal_i & b_denormal_i) begin
      z_o         = zero_word;   // flushed
      underflow_o = 1'b1;
    end else if (a_denormal_i | b_denormal_i) begin
      z_o             = fmul_special_pkg::quiet_nan_word;
      unimplemented_o = 1'b1;
    end else if (sum_low) begin
      z_o         = zero_word;
      underflow_o = 1'b1;
    end else if (sum_high | exp_carry_i | round_carry
                 | (rounded_exp == fmul_special_pkg::exp_all_ones)) begin
      z_o        = infty_word;
      overflow_o = 1'b1;
    end else if (rounded_exp == '0) begin
      z_o         = zero_word;   // would be denormal
      underflow_o = 1'b1;
    end
  end

endmodule

//--- hw/fmul_top.sv
// ################################################
// single precision multiplier top
// flow control plus three stage datapath
// ################################################

`timescale 1ns/1ps

module fmul_top (
  input  logic                     clk_i
  , input  logic                   reset_i
  , input  logic                   en_i
  , input  logic                   v_i
  , input  fmul_fmt_pkg::fp_word_t a_i
  , input  fmul_fmt_pkg::fp_word_t b_i
  , output logic                   ready_o
  , output logic                   v_o
  , output fmul_fmt_pkg::fp_word_t z_o
  , output logic                   invalid_o
  , output logic                   overflow_o
  , output logic                   underflow_o
  , output logic                   unimplemented_o
  , input  logic                   yumi_i
);

  logic load_1, load_2, load_3;

  logic sign_1, sign_2, sign_3;
  fmul_fmt_pkg::exp_ext_t exp_sum_1, exp_sum_2, exp_sum_3;
  fmul_fmt_pkg::exp_t exp_unb_1, exp_unb_2;
  fmul_fmt_pkg::sig_t sig_a_1, sig_b_1;
  fmul_fmt_pkg::prod_t prod_2;
  fmul_fmt_pkg::body_t pre_round_3;
  logic round_up_3, exp_carry_3;

  logic a_sig_nan_1, b_sig_nan_1, a_nan_1, b_nan_1, a_infty_1, b_infty_1;
  logic a_zero_1, b_zero_1, a_denormal_1, b_denormal_1;
  logic a_sig_nan_2, b_sig_nan_2, a_nan_2, b_nan_2, a_infty_2, b_infty_2;
  logic a_zero_2, b_zero_2, a_denormal_2, b_denormal_2;
  logic a_sig_nan_3, b_sig_nan_3, a_nan_3, b_nan_3, a_infty_3, b_infty_3;
  logic a_zero_3, b_zero_3, a_denormal_3, b_denormal_3;

  fmul_pipe_ctrl i_pipe_ctrl (
    .clk_i(clk_i), .reset_i(reset_i), .en_i(en_i), .v_i(v_i), .yumi_i(yumi_i)
    , .ready_o(ready_o), .v_o(v_o)
    , .load_1_o(load_1), .load_2_o(load_2), .load_3_o(load_3)
  );

  fmul_operand_stage i_operand_stage (
    .clk_i(clk_i), .load_i(load_1), .a_i(a_i), .b_i(b_i)
    , .sign_o(sign_1), .exp_sum_o(exp_sum_1), .exp_unbiased_o(exp_unb_1)
    , .sig_a_o(sig_a_1), .sig_b_o(sig_b_1)
    , .a_sig_nan_o(a_sig_nan_1), .b_sig_nan_o(b_sig_nan_1)
    , .a_nan_o(a_nan_1), .b_nan_o(b_nan_1)
    , .a_infty_o(a_infty_1), .b_infty_o(b_infty_1)
    , .a_zero_o(a_zero_1), .b_zero_o(b_zero_1)
    , .a_denormal_o(a_denormal_1), .b_denormal_o(b_denormal_1)
  );

  fmul_product_stage i_product_stage (
    .clk_i(clk_i), .load_i(load_2), .sig_a_i(sig_a_1), .sig_b_i(sig_b_1)
    , .sign_i(sign_1), .exp_sum_i(exp_sum_1), .exp_unbiased_i(exp_unb_1)
    , .a_sig_nan_i(a_sig_nan_1), .b_sig_nan_i(b_sig_nan_1)
    , .a_nan_i(a_nan_1), .b_nan_i(b_nan_1)
    , .a_infty_i(a_infty_1), .b_infty_i(b_infty_1)
    , .a_zero_i(a_zero_1), .b_zero_i(b_zero_1)
    , .a_denormal_i(a_denormal_1), .b_denormal_i(b_denormal_1)
    , .prod_o(prod_2)
    , .sign_o(sign_2), .exp_sum_o(exp_sum_2), .exp_unbiased_o(exp_unb_2)
    , .a_sig_nan_o(a_sig_nan_2), .b_sig_nan_o(b_sig_nan_2)
    , .a_nan_o(a_nan_2), .b_nan_o(b_nan_2)
    , .a_infty_o(a_infty_2), .b_infty_o(b_infty_2)
    , .a_zero_o(a_zero_2), .b_zero_o(b_zero_2)
    , .a_denormal_o(a_denormal_2), .b_denormal_o(b_denormal_2)
  );

  fmul_round_stage i_round_stage (
    .clk_i(clk_i), .load_i(load_3), .prod_i(prod_2), .exp_unbiased_i(exp_unb_2)
    , .sign_i(sign_2), .exp_sum_i(exp_sum_2)
    , .a_sig_nan_i(a_sig_nan_2), .b_sig_nan_i(b_sig_nan_2)
    , .a_nan_i(a_nan_2), .b_nan_i(b_nan_2)
    , .a_infty_i(a_infty_2), .b_infty_i(b_infty_2)
    , .a_zero_i(a_zero_2), .b_zero_i(b_zero_2)
    , .a_denormal_i(a_denormal_2), .b_denormal_i(b_denormal_2)
    , .pre_round_o(pre_round_3), .round_up_o(round_up_3), .exp_carry_o(exp_carry_3)
    , .sign_o(sign_3), .exp_sum_o(exp_sum_3)
    , .a_sig_nan_o(a_sig_nan_3), .b_sig_nan_o(b_sig_nan_3)
    , .a_nan_o(a_nan_3), .b_nan_o(b_nan_3)
    , .a_infty_o(a_infty_3), .b_infty_o(b_infty_3)
    , .a_zero_o(a_zero_3), .b_zero_o(b_zero_3)
    , .a_denormal_o(a_denormal_3), .b_denormal_o(b_denormal_3)
  );

  fmul_result_select i_result_select (
    .sign_i(sign_3), .pre_round_i(pre_round_3), .round_up_i(round_up_3)
    , .exp_carry_i(exp_carry_3), .exp_sum_i(exp_sum_3)
    , .a_sig_nan_i(a_sig_nan_3), .b_sig_nan_i(b_sig_nan_3)
    , .a_nan_i(a_nan_3), .b_nan_i(b_nan_3)
    , .a_infty_i(a_infty_3), .b_infty_i(b_infty_3)
    , .a_zero_i(a_zero_3), .b_zero_i(b_zero_3)
    , .a_denormal_i(a_denormal_3), .b_denormal_i(b_denormal_3)
    , .z_o(z_o), .invalid_o(invalid_o), .overflow_o(overflow_o)
    , .underflow_o(underflow_o), .unimplemented_o(unimplemented_o)
  );

endmodule

//--- tb/fmul_clk_gen.sv
// ################################################
// testbench clock and reset
// 8 ns clock, reset held for 8 cycles
// ################################################

`timescale 1ns/1ps

module fmul_clk_gen (
  output logic clk_o
  , output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;   // released away from the sampling edge
  end

endmodule

//--- tb/fmul_assert.sv
// ################################################
// flow control assertions of the multiplier
// reset state, hold under stall, ready gating
// ################################################

`timescale 1ns/1ps

module fmul_assert (
  input  logic                   clk_i
  , input  logic                 reset_i
  , input  logic                 en_i
  , input  logic                 yumi_i
  , input  logic                 ready_o
  , input  logic                 v_o
  , input  fmul_fmt_pkg::fp_word_t z_o
  , input  logic [3:0]           flags_i
);

  // nothing valid in the cycle after reset
  a_v_low_after_reset : assert property (@(posedge clk_i) reset_i |=> !v_o)
    else $error("v_o high in the cycle after reset");

  // held result must not move until consumed
  a_hold_while_stalled : assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(z_o) && $stable(flags_i)))
    else $error("result changed while stalled");

  a_ready_needs_en : assert property (@(posedge clk_i) disable iff (reset_i)
    !en_i |-> !ready_o)
    else $error("ready_o high while en_i low");

endmodule

bind fmul_top fmul_assert i_fmul_assert (
  .clk_i(clk_i), .reset_i(reset_i), .en_i(en_i), .yumi_i(yumi_i)
  , .ready_o(ready_o), .v_o(v_o), .z_o(z_o)
  , .flags_i({invalid_o, overflow_o, underflow_o, unimplemented_o})
);

//--- tb/fmul_tb.sv
// ################################################
// multiplier testbench
// pattern driver on the falling edge, in order checker
// with random yumi, latency and en freeze phases
// ################################################

`timescale 1ns/1ps

module fmul_tb;

  localparam int max_patterns   = 64;
  localparam int timeout_cycles = 100;
  localparam int freeze_cycles  = 6;

  logic clk, reset;
  logic en, v_in, yumi, ready, v_out;
  fmul_fmt_pkg::fp_word_t a_in, b_in, z_out;
  logic invalid, overflow, underflow, unimplemented;

  logic [31:0] pattern_mem [0:4*max_patterns-1];  // a, b, z, flags
  int num_patterns;
  int test_phase;   // 0 yumi high, 1 random yumi, 2 random yumi plus en gaps
  int results_seen;
  int cycle_count;
  int offer_edge_q[$];
  logic [31:0] lcg_state;

  fmul_clk_gen i_clk_gen (.clk_o(clk), .reset_o(reset));

  fmul_top i_fmul_top (
    .clk_i(clk), .reset_i(reset), .en_i(en), .v_i(v_in), .a_i(a_in), .b_i(b_in)
    , .ready_o(ready), .v_o(v_out), .z_o(z_out), .invalid_o(invalid)
    , .overflow_o(overflow), .underflow_o(underflow)
    , .unimplemented_o(unimplemented), .yumi_i(yumi)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual)
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
  endtask

  // offer one pattern until the DUT takes it
  task automatic send_pattern(input int idx);
    int waited;
    bit accepted;
    waited = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      en = 1'b1;
      v_in = 1'b1;
      a_in = pattern_mem[4*idx];
      b_in = pattern_mem[4*idx+1];
      #2;   // yumi has settled so ready holds until the rising edge
      if (ready) begin
        accepted = 1'b1;
        offer_edge_q.push_back(cycle_count);
      end else if (waited >= timeout_cycles) begin
        stop_with_failure($sformatf("pattern %0d was never accepted", idx));
      end
      waited++;
    end
  endtask

  task automatic freeze_pipeline(input int idx);
    repeat (freeze_cycles) begin
      @(negedge clk);
      en = 1'b0;
      v_in = 1'b1;
      a_in = pattern_mem[4*idx];
      b_in = pattern_mem[4*idx+1];
      #2;
      compare($sformatf("frozen ready before pattern %0d", idx), 32'd0, ready);
    end
  endtask

  task automatic run_phase(input int phase_id);
    int waited;
    int target;
    test_phase = phase_id;
    target = results_seen + num_patterns;
    for (int i = 0; i < num_patterns; i++) begin
      if (phase_id == 2 && i % 5 == 2) freeze_pipeline(i);
      send_pattern(i);
    end
    @(negedge clk);
    v_in = 1'b0;
    waited = 0;
    while (results_seen < target) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles)
        stop_with_failure($sformatf("phase %0d did not drain its results", phase_id));
    end
  endtask

  task automatic check_result();
    int idx;
    int offered_at;
    string tag;
    idx = results_seen % num_patterns;
    tag = $sformatf("phase %0d pattern %0d", test_phase, idx);
    if (offer_edge_q.size() == 0)
      stop_with_failure("a result appeared with no operand in flight");
    offered_at = offer_edge_q.pop_front();
    compare({tag, " z"}, pattern_mem[4*idx+2], z_out);
    compare({tag, " flags"}, pattern_mem[4*idx+3] & 32'hF,
            {28'd0, invalid, overflow, underflow, unimplemented});
    if (test_phase == 0) compare({tag, " latency"}, 32'd3, cycle_count - offered_at);
    results_seen++;
  endtask

  // consumer raises yumi only together with en
  initial begin : consume
    forever begin
      @(negedge clk);
      #1;
      lcg_state = next_random(lcg_state);
      if (test_phase == 0) yumi = en;
      else yumi = en & lcg_state[16];
      if (v_out === 1'b1 && yumi) check_result();
    end
  end

  initial begin : main
    int waited;
    en = 1'b0;
    v_in = 1'b0;
    yumi = 1'b0;
    a_in = '0;
    b_in = '0;
    cycle_count = 0;
    results_seen = 0;
    test_phase = 0;
    num_patterns = 0;
    lcg_state = 32'ha9a9;
    $readmemh("tb/fmul_patterns.hex", pattern_mem);
    while (num_patterns < max_patterns && !$isunknown(pattern_mem[4*num_patterns]))
      num_patterns++;
    if (num_patterns == 0) stop_with_failure("no patterns read from tb/fmul_patterns.hex");
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) stop_with_failure("reset was never released");
    end while (reset !== 1'b0);
    #2;
    compare("ready after reset", 32'd0, ready);
    compare("v_o after reset", 32'd0, v_out);
    run_phase(0);
    run_phase(1);
    run_phase(2);
    repeat (5) @(negedge clk);   // any late extra result would show up here
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb/fmul_patterns.hex
// columns: operand a, operand b, expected z, expected flags
// flag bits from msb: invalid, overflow, underflow, unimplemented
3f800000 3f800000 3f800000 0
3fc00000 40000000 40400000 0
3fc00000 3fc00000 40100000 0
c0000000 40400000 c0c00000 0
3e800000 41200000 40200000 0
3f800001 3f800001 3f800002 0
3fffffff 3fffffff 407ffffe 0
3fc00000 3f800001 3fc00002 0
3fc00000 3f800003 3fc00004 0
3fc00001 3f800003 3fc00006 0
3f8003e8 3ffff830 40000000 0
7f800001 3f800000 7fa00000 8
3f800000 7fc00000 7fc00000 0
7f800000 00000000 7fc00000 8
80000000 ff800000 7fc00000 8
ff800000 40000000 ff800000 0
80000000 3f800000 80000000 0
7f000000 7f000000 7f800000 4
7f000000 40000000 7f800000 4
7f400000 40400000 7f800000 4
80800000 00800000 80000000 2
00800000 3f000000 00000000 2
00000001 00400000 00000000 2
00400000 3f800000 7fc00000 1

//--- sim.f
hw/fmul_fmt_pkg.sv
hw/fmul_special_pkg.sv
hw/fmul_operand_classify.sv
hw/fmul_pipe_ctrl.sv
hw/fmul_operand_stage.sv
hw/fmul_product_stage.sv
hw/fmul_round_stage.sv
hw/fmul_result_select.sv
hw/fmul_top.sv
tb/fmul_clk_gen.sv
tb/fmul_assert.sv
tb/fmul_tb.sv
